/* all.f */
+incdir+.
poly_mm_data_pkg.sv
poly_mm_modulus_pkg.sv
poly_mm_link_if.sv
barrett_estimate_stage.sv
barrett_quotient_stage.sv
barrett_reduce_stage.sv
barrett_correct_stage.sv
poly_mm_top.sv
poly_mm_assertions.sv
poly_mm_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module poly_mm_tb -f all.f -o poly_mm_sim > build.log 2>&1 &&
{ ./obj_dir/poly_mm_sim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q '^STATUS: PASS$' sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

/* poly_mm_tb.sv */
`timescale 1ns/1ps
`include "poly_mm_cfg.svh"

module poly_mm_tb;
    import poly_mm_data_pkg::*;
    import poly_mm_modulus_pkg::*;

    localparam int DRAIN_LIMIT = 64;

    logic           poly_mm_clk;
    logic           poly_mm_rst_n;
    logic           poly_mm_enable;
    operand_t       poly_mm_a;
    operand_t       poly_mm_b;
    modulus_t       poly_mm_q;
    barrett_const_t poly_mm_m;
    width_sel_t     poly_mm_n;
    logic           poly_mm_valid;
    operand_t       poly_mm_result;

    // expected results in issue order
    operand_t    exp_q[$];
    operand_t    last_result;
    logic [31:0] rng_state = 32'h1719_ac34;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          ops = 0;
    int          test_checks0 = 0;
    int          test_errors0 = 0;
    bit          timed_out = 1'b0;

    poly_mm_top dut0 (
        .poly_mm_clk    (poly_mm_clk),
        .poly_mm_rst_n  (poly_mm_rst_n),
        .poly_mm_enable (poly_mm_enable),
        .poly_mm_a      (poly_mm_a),
        .poly_mm_b      (poly_mm_b),
        .poly_mm_q      (poly_mm_q),
        .poly_mm_m      (poly_mm_m),
        .poly_mm_n      (poly_mm_n),
        .poly_mm_valid  (poly_mm_valid),
        .poly_mm_result (poly_mm_result)
    );

    initial begin
        poly_mm_clk = 1'b0;
        forever #4 poly_mm_clk = ~poly_mm_clk;
    end

    // xorshift32, one step per call
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // bit-exact model of the four stages
    function automatic operand_t expected_result(operand_t a, operand_t b, modulus_t q,
                                                 barrett_const_t m, width_sel_t n);
        int unsigned w;
        logic [63:0] mask;
        logic [63:0] p0;
        logic [63:0] t0;
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] r;
        w = (n == 0 || n > `POLY_MM_N_MAX) ? `POLY_MM_N_MAX : int'(n);
        mask = (64'd1 << (w + 1)) - 64'd1;
        p0 = 64'(a) * 64'(b);
        t0 = (p0 >> (w - 1)) & 64'h1ff_ffff;
        t1 = ((t0 * 64'(m)) >> (w + 1)) & 64'h1ff_ffff;
        t2 = (t1 * 64'(q)) & mask;
        // low part minus t2, wrapped then cut to N+1 bits
        r = ((p0 & mask) - t2) & mask;
        if (r >= 64'(q)) begin
            r = r - 64'(q);
        end
        return operand_t'(r);
    endfunction

    // top set bit at N-1
    function automatic modulus_t pick_modulus(int unsigned w);
        logic [31:0] top;
        logic [31:0] q;
        top = 32'd1 << (w - 1);
        q = top | (next_rand() & (top - 32'd1));
        // odd above N = 1, so m stays inside 25 bits at N = 24
        if (w > 1) begin
            q = q | 32'd1;
        end
        return modulus_t'(q);
    endfunction

    // m = floor(2^(2N) / q)
    function automatic barrett_const_t reciprocal(modulus_t q, int unsigned w);
        logic [63:0] quo;
        quo = (64'd1 << (2 * w)) / 64'(q);
        return barrett_const_t'(quo);
    endfunction

    function automatic operand_t below(modulus_t q);
        return operand_t'(next_rand() % 32'(q));
    endfunction

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // one accepted operation, model result queued at once
    task automatic drive_op(operand_t a, operand_t b, modulus_t q, barrett_const_t m,
                            width_sel_t n);
        @(posedge poly_mm_clk);
        poly_mm_enable <= 1'b1;
        poly_mm_a      <= a;
        poly_mm_b      <= b;
        poly_mm_q      <= q;
        poly_mm_m      <= m;
        poly_mm_n      <= n;
        exp_q.push_back(expected_result(a, b, q, m, n));
        ops++;
    endtask

    // idle cycle, junk operands must be ignored
    task automatic drive_gap();
        @(posedge poly_mm_clk);
        poly_mm_enable <= 1'b0;
        poly_mm_a      <= operand_t'(next_rand());
        poly_mm_b      <= operand_t'(next_rand());
    endtask

    task automatic start_test();
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic wait_drained(string what);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge poly_mm_clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %s still waits for %0d results after %0d cycles",
                     what, exp_q.size(), cycles);
            timed_out = 1'b1;
        end
        // a few quiet cycles, any stray valid shows up here
        repeat (`POLY_MM_LATENCY + 1) @(negedge poly_mm_clk);
    endtask

    task automatic finish_test(string name);
        wait_drained(name);
        tests++;
        $display("test %-34s checks %5d  errors %0d",
                 name, checks - test_checks0, errors - test_errors0);
    endtask

    // compare at the falling edge, outputs settled by then
    initial begin
        operand_t exp;
        last_result = '0;
        forever begin
            @(negedge poly_mm_clk);
            if (poly_mm_rst_n === 1'b1 && poly_mm_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("poly_mm_valid went high at %0t ns with no operation pending",
                             $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    check_value("poly_mm_result", exp, poly_mm_result);
                end
                last_result = poly_mm_result;
            end else if (poly_mm_rst_n === 1'b1) begin
                // held between valid outputs
                check_value("poly_mm_result (hold)", last_result, poly_mm_result);
            end
        end
    end

    initial begin
        operand_t       a;
        operand_t       b;
        modulus_t       q;
        barrett_const_t m;
        int unsigned    w;
        int             cycles;
        operand_t       vals[3];
        int             bad[3];
        poly_mm_rst_n  = 1'b0;
        poly_mm_enable = 1'b0;
        poly_mm_a      = '0;
        poly_mm_b      = '0;
        poly_mm_q      = '0;
        poly_mm_m      = '0;
        poly_mm_n      = '0;
        repeat (5) @(posedge poly_mm_clk);
        poly_mm_rst_n <= 1'b1;

        // nothing comes out before the first operation
        start_test();
        repeat (6) begin
            @(negedge poly_mm_clk);
            check_value("poly_mm_valid", 0, poly_mm_valid);
            check_value("poly_mm_result", 0, poly_mm_result);
        end
        finish_test("idle after reset");

        // kyber modulus, (q-1)^2 mod q is 1
        start_test();
        drive_op(24'd3328, 24'd3328, 24'd3329, 25'd5039, 5'd12);
        drive_gap();
        // edges counted from the one that raised enable
        // the gap edge is already the first of them
        cycles = 1;
        while (poly_mm_valid !== 1'b1 && cycles < DRAIN_LIMIT) begin
            @(posedge poly_mm_clk);
            cycles++;
            @(negedge poly_mm_clk);
        end
        if (poly_mm_valid !== 1'b1) begin
            $display("timeout: single operation never raised poly_mm_valid");
            timed_out = 1'b1;
        end
        check_value("latency", `POLY_MM_LATENCY, cycles);
        check_value("poly_mm_result (mod)", (64'd3328 * 64'd3328) % 64'd3329, poly_mm_result);
        finish_test("single op q=3329 N=12");

        // new q, m, N on every cycle, four in flight
        start_test();
        repeat (200) begin
            w = 1 + next_rand() % 24;
            q = pick_modulus(w);
            a = below(q);
            b = below(q);
            drive_op(a, b, q, reciprocal(q, w), width_sel_t'(w));
        end
        drive_gap();
        finish_test("burst of 200 back to back");

        start_test();
        repeat (100) begin
            repeat (next_rand() % 4) drive_gap();
            w = 1 + next_rand() % 24;
            q = pick_modulus(w);
            a = below(q);
            b = below(q);
            drive_op(a, b, q, reciprocal(q, w), width_sel_t'(w));
        end
        drive_gap();
        finish_test("random gaps in enable");

        // corner operands at every legal width
        start_test();
        for (int n = 1; n <= `POLY_MM_N_MAX; n++) begin
            q = pick_modulus(n);
            vals[0] = '0;
            vals[1] = operand_t'(1);
            vals[2] = q - 1;
            foreach (vals[i]) begin
                foreach (vals[j]) begin
                    drive_op(vals[i], vals[j], q, reciprocal(q, n), width_sel_t'(n));
                end
            end
        end
        drive_gap();
        finish_test("width sweep N=1..24");

        // illegal N paired with N = 24 on the same operands
        start_test();
        bad = '{0, 25, 31};
        foreach (bad[k]) begin
            repeat (10) begin
                q = pick_modulus(24);
                a = below(q);
                b = below(q);
                m = reciprocal(q, 24);
                drive_op(a, b, q, m, 5'd24);
                drive_op(a, b, q, m, width_sel_t'(bad[k]));
            end
        end
        drive_gap();
        finish_test("illegal N as 24");

        $display("summary: %0d tests, %0d operations, %0d checks, %0d errors%s",
                 tests, ops, checks, errors, timed_out ? ", timed out" : "");
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* poly_mm_assertions.sv */
`timescale 1ns/1ps
`include "poly_mm_cfg.svh"

module poly_mm_assertions (
    input logic                       poly_mm_clk,
    input logic                       poly_mm_rst_n,
    input logic                       poly_mm_enable,
    input logic                       poly_mm_valid,
    input poly_mm_data_pkg::operand_t poly_mm_result
);

    // output register clears on the reset edge itself
    // so the check looks one edge later
    reset_quiet: assert property (
        @(posedge poly_mm_clk) !poly_mm_rst_n |=> !poly_mm_valid
    ) else $error("poly_mm_valid high while reset is active");

    // no stalls, valid is enable delayed by the pipeline depth
    valid_latency: assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        poly_mm_valid == $past(poly_mm_enable, `POLY_MM_LATENCY)
    ) else $error("poly_mm_valid does not follow poly_mm_enable by the pipeline latency");

    // result only moves on the edge that raises valid
    result_hold: assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        !poly_mm_valid |-> $stable(poly_mm_result)
    ) else $error("poly_mm_result changed while poly_mm_valid was low");

endmodule

bind poly_mm_top poly_mm_assertions u_assertions (
    .poly_mm_clk    (poly_mm_clk),
    .poly_mm_rst_n  (poly_mm_rst_n),
    .poly_mm_enable (poly_mm_enable),
    .poly_mm_valid  (poly_mm_valid),
    .poly_mm_result (poly_mm_result)
);

/* poly_mm_top.sv */
`timescale 1ns/1ps

module poly_mm_top (
    input  logic                                poly_mm_clk,
    input  logic                                poly_mm_rst_n,
    input  logic                                poly_mm_enable,
    input  poly_mm_data_pkg::operand_t          poly_mm_a,
    input  poly_mm_data_pkg::operand_t          poly_mm_b,
    input  poly_mm_modulus_pkg::modulus_t       poly_mm_q,
    input  poly_mm_modulus_pkg::barrett_const_t poly_mm_m,
    input  poly_mm_modulus_pkg::width_sel_t     poly_mm_n,
    output logic                                poly_mm_valid,
    output poly_mm_data_pkg::operand_t          poly_mm_result
);
    import poly_mm_modulus_pkg::*;

    // q, m, N bundled for the trip down the pipeline
    modulus_ctx_t in_ctx;

    assign in_ctx = '{q: poly_mm_q, m: poly_mm_m, n: poly_mm_n};

    // stage 1 to 2
    poly_mm_link_if est_link ();
    // stage 2 to 3
    poly_mm_link_if quo_link ();
    // stage 3 to 4
    poly_mm_link_if red_link ();

    // a*b, t0 and the masked low part
    barrett_estimate_stage u_estimate (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .enable        (poly_mm_enable),
        .a             (poly_mm_a),
        .b             (poly_mm_b),
        .ctx           (in_ctx),
        .out_link      (est_link.src)
    );

    // t1 from t0 * m
    barrett_quotient_stage u_quotient (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .in_link       (est_link.dst),
        .out_link      (quo_link.src)
    );

    // t2 from t1 * q
    barrett_reduce_stage u_reduce (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .in_link       (quo_link.dst),
        .out_link      (red_link.src)
    );

    // subtract, mask, final correction
    barrett_correct_stage u_correct (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .in_link       (red_link.dst),
        .result        (poly_mm_result),
        .valid         (poly_mm_valid)
    );

endmodule

/* barrett_correct_stage.sv */
`timescale 1ns/1ps

module barrett_correct_stage (
    input  logic                       poly_mm_clk,
    input  logic                       poly_mm_rst_n,
    poly_mm_link_if.dst                in_link,
    output poly_mm_data_pkg::operand_t result,
    output logic                       valid
);
    import poly_mm_data_pkg::*;
    import poly_mm_modulus_pkg::*;

    width_sel_t n_eff;
    residue_t   q_ext;
    residue_t   r_raw;
    residue_t   r;
    residue_t   r_sub;
    operand_t   result_next;

    always_comb begin
        n_eff = legal_sel(in_link.ctx.n);
        q_ext = residue_t'(in_link.ctx.q);

        // low - t2, wraps modulo 2^25
        r_raw = in_link.low - in_link.value;

        // keep N+1 bits
        r = r_raw & sel_mask(n_eff);

        // estimate is at most one q short, a single correction
        r_sub = r - q_ext;
        result_next = (r < q_ext) ? operand_t'(r) : operand_t'(r_sub);
    end

    // result holds between valid outputs
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            valid  <= 1'b0;
            result <= '0;
        end else begin
            valid <= in_link.valid;
            if (in_link.valid) begin
                result <= result_next;
            end
        end
    end

endmodule

/* barrett_reduce_stage.sv */
`timescale 1ns/1ps

module barrett_reduce_stage (
    input  logic        poly_mm_clk,
    input  logic        poly_mm_rst_n,
    poly_mm_link_if.dst in_link,
    poly_mm_link_if.src out_link
);
    import poly_mm_data_pkg::*;
    import poly_mm_modulus_pkg::*;

    width_sel_t n_eff;
    residue_t   p2_low;
    residue_t   t2;

    always_comb begin
        n_eff = legal_sel(in_link.ctx.n);

        // t1 * q, only the low 25 bits matter
        // so the multiply is sized to the residue width
        p2_low = in_link.value * residue_t'(in_link.ctx.q);

        // N+1 low bits, same mask as the low part of a*b
        t2 = p2_low & sel_mask(n_eff);
    end

    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            out_link.valid <= 1'b0;
        end else begin
            out_link.valid <= in_link.valid;
        end
    end

    // item advances one stage
    always_ff @(posedge poly_mm_clk) begin
        if (in_link.valid) begin
            out_link.ctx   <= in_link.ctx;
            out_link.low   <= in_link.low;
            out_link.value <= t2;
        end
    end

endmodule

/* barrett_quotient_stage.sv */
`timescale 1ns/1ps
`include "poly_mm_cfg.svh"

module barrett_quotient_stage (
    input  logic        poly_mm_clk,
    input  logic        poly_mm_rst_n,
    poly_mm_link_if.dst in_link,
    poly_mm_link_if.src out_link
);
    import poly_mm_data_pkg::*;
    import poly_mm_modulus_pkg::*;

    width_sel_t                          n_eff;
    logic [2*`POLY_MM_RESIDUE_W-1:0]     p1;
    residue_t                            t1;

    always_comb begin
        n_eff = legal_sel(in_link.ctx.n);

        // t0 * m, 50 bits wide
        p1 = (2*`POLY_MM_RESIDUE_W)'(in_link.value) * (2*`POLY_MM_RESIDUE_W)'(in_link.ctx.m);

        // quotient estimate, 25 bits from bit N+1
        t1 = residue_t'(p1 >> (n_eff + width_sel_t'(1)));
    end

    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            out_link.valid <= 1'b0;
        end else begin
            out_link.valid <= in_link.valid;
        end
    end

    // low and ctx ride along with the item
    always_ff @(posedge poly_mm_clk) begin
        if (in_link.valid) begin
            out_link.ctx   <= in_link.ctx;
            out_link.low   <= in_link.low;
            out_link.value <= t1;
        end
    end

endmodule

/* barrett_estimate_stage.sv */
`timescale 1ns/1ps

module barrett_estimate_stage (
    input  logic                              poly_mm_clk,
    input  logic                              poly_mm_rst_n,
    input  logic                              enable,
    input  poly_mm_data_pkg::operand_t        a,
    input  poly_mm_data_pkg::operand_t        b,
    input  poly_mm_modulus_pkg::modulus_ctx_t ctx,
    poly_mm_link_if.src                       out_link
);
    import poly_mm_data_pkg::*;
    import poly_mm_modulus_pkg::*;

    width_sel_t n_eff;
    product_t   p0;
    residue_t   t0;
    residue_t   low;

    always_comb begin
        // illegal N replaced before any select
        n_eff = legal_sel(ctx.n);

        // full 48-bit product
        p0 = product_t'(a) * product_t'(b);

        // 25 bits of p0 from bit N-1 upward
        t0 = residue_t'(p0 >> (n_eff - width_sel_t'(1)));

        // N+1 low bits, rest cleared
        low = residue_t'(p0) & sel_mask(n_eff);
    end

    // control, cleared on reset
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            out_link.valid <= 1'b0;
        end else begin
            out_link.valid <= enable;
        end
    end

    // payload only loads with an accepted operation
    // raw ctx kept, later stages legalize N themselves
    always_ff @(posedge poly_mm_clk) begin
        if (enable) begin
            out_link.ctx   <= ctx;
            out_link.low   <= low;
            out_link.value <= t0;
        end
    end

endmodule

/* poly_mm_link_if.sv */
`timescale 1ns/1ps

interface poly_mm_link_if;
    import poly_mm_data_pkg::*;
    import poly_mm_modulus_pkg::*;

    // item present on this link
    logic         valid;
    // q, m, N belonging to this item
    modulus_ctx_t ctx;
    // masked low part of a*b, needed again in the last stage
    residue_t     low;
    // result of the producing stage
    residue_t     value;

    // producing stage, all four from its registers
    modport src (
        output valid,
        output ctx,
        output low,
        output value
    );

    // consuming stage, read only
    modport dst (
        input valid,
        input ctx,
        input low,
        input value
    );

endinterface

/* poly_mm_modulus_pkg.sv */
`include "poly_mm_cfg.svh"

package poly_mm_modulus_pkg;

    // modulus q, top set bit sits at N-1
    typedef logic [`POLY_MM_OPERAND_W-1:0] modulus_t;

    // barrett constant, floor(2^(2N) / q)
    typedef logic [`POLY_MM_RESIDUE_W-1:0] barrett_const_t;

    // width selector N
    typedef logic [`POLY_MM_SEL_W-1:0] width_sel_t;

    // travels with each item so q, m, N may change every cycle
    typedef struct packed {
        modulus_t       q;
        barrett_const_t m;
        width_sel_t     n;
    } modulus_ctx_t;

    // N outside 1..24 behaves as 24
    function automatic width_sel_t legal_sel(width_sel_t n);
        if (n == '0 || n > width_sel_t'(`POLY_MM_N_MAX)) begin
            return width_sel_t'(`POLY_MM_N_MAX);
        end
        return n;
    endfunction

    // N+1 low ones, all 25 bits set for N = 24
    function automatic logic [`POLY_MM_RESIDUE_W-1:0] sel_mask(width_sel_t n);
        return ~({`POLY_MM_RESIDUE_W{1'b1}} << (n + 1));
    endfunction

endpackage

/* poly_mm_data_pkg.sv */
`include "poly_mm_cfg.svh"

package poly_mm_data_pkg;

    // a, b and the final residue
    typedef logic [`POLY_MM_OPERAND_W-1:0] operand_t;

    // one extra bit of headroom over the operand
    // t0, t1, t2 and the masked low part of a*b all use this
    typedef logic [`POLY_MM_RESIDUE_W-1:0] residue_t;

    // full a*b, never truncated before the t0 select
    typedef logic [2*`POLY_MM_OPERAND_W-1:0] product_t;

endpackage

/* poly_mm_cfg.svh */
`ifndef POLY_MM_CFG_SVH
`define POLY_MM_CFG_SVH

// operand width, also the width of q
`define POLY_MM_OPERAND_W 24

// width of m and of the t0/t1/t2 intermediates
`define POLY_MM_RESIDUE_W 25

// width selector field
`define POLY_MM_SEL_W 5

// largest legal width, used whenever N is out of range
`define POLY_MM_N_MAX 24

// enable to valid, one cycle per stage
`define POLY_MM_LATENCY 4

`endif
